/* filelist.f */
source/usb_xfer_pkg.sv
source/xfer_req_if.sv
source/token_decoder.sv
source/xfer_sequencer.sv
source/in_data_mover.sv
source/usb_xfer_top.sv
testbench/usb_xfer_checker.sv
testbench/usb_xfer_chk.sv
testbench/tb_usb_xfer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bulk transfer testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_usb_xfer \
  -f filelist.f \
  -Mdir obj_dir \
  -o sim_usb_xfer
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_usb_xfer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/tb_usb_xfer.sv */
`timescale 1ns/1ps

module tb_usb_xfer;
  import usb_xfer_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS = 11;

  // One transaction: flag is has_data for IN and ready_read for OUT
  typedef struct {
    token_t    tok;
    endpoint_t ep;
    logic      flag;
    int        bytes;
    logic      last;
    hsk_t      host;
  } row_t;

  row_t rows [NUM_ROWS];

  logic clk;
  logic rst;
  token_t trn_type;
  endpoint_t trn_endpoint;
  logic trn_start;
  byte_t rx_trn_data;
  logic rx_trn_valid;
  logic rx_trn_end;
  hsk_t rx_trn_hsk_type;
  logic rx_trn_hsk_received;
  hsk_t tx_trn_hsk_type;
  logic tx_trn_send_hsk;
  logic tx_trn_hsk_sended;
  logic [1:0] tx_trn_data_type;
  logic tx_trn_data_start;
  byte_t tx_trn_data;
  logic tx_trn_data_valid;
  logic tx_trn_data_ready;
  logic tx_trn_data_last;
  endpoint_t blk_xfer_endpoint;
  logic blk_in_xfer;
  logic blk_out_xfer;
  logic blk_xfer_in_has_data;
  byte_t blk_xfer_in_data;
  logic blk_xfer_in_data_valid;
  logic blk_xfer_in_data_ready;
  logic blk_xfer_in_data_last;
  logic blk_xfer_out_ready_read;
  byte_t blk_xfer_out_data;
  logic blk_xfer_out_data_valid;

  int row_idx;
  int row_bytes;
  logic row_last;
  int errors;
  int checks;
  int cycles;
  int limit;

  usb_xfer_top i_dut (
    .clk                     (clk),
    .rst                     (rst),
    .trn_type                (trn_type),
    .trn_endpoint            (trn_endpoint),
    .trn_start               (trn_start),
    .rx_trn_data             (rx_trn_data),
    .rx_trn_valid            (rx_trn_valid),
    .rx_trn_end              (rx_trn_end),
    .rx_trn_hsk_type         (rx_trn_hsk_type),
    .rx_trn_hsk_received     (rx_trn_hsk_received),
    .tx_trn_hsk_type         (tx_trn_hsk_type),
    .tx_trn_send_hsk         (tx_trn_send_hsk),
    .tx_trn_hsk_sended       (tx_trn_hsk_sended),
    .tx_trn_data_type        (tx_trn_data_type),
    .tx_trn_data_start       (tx_trn_data_start),
    .tx_trn_data             (tx_trn_data),
    .tx_trn_data_valid       (tx_trn_data_valid),
    .tx_trn_data_ready       (tx_trn_data_ready),
    .tx_trn_data_last        (tx_trn_data_last),
    .blk_xfer_endpoint       (blk_xfer_endpoint),
    .blk_in_xfer             (blk_in_xfer),
    .blk_out_xfer            (blk_out_xfer),
    .blk_xfer_in_has_data    (blk_xfer_in_has_data),
    .blk_xfer_in_data        (blk_xfer_in_data),
    .blk_xfer_in_data_valid  (blk_xfer_in_data_valid),
    .blk_xfer_in_data_ready  (blk_xfer_in_data_ready),
    .blk_xfer_in_data_last   (blk_xfer_in_data_last),
    .blk_xfer_out_ready_read (blk_xfer_out_ready_read),
    .blk_xfer_out_data       (blk_xfer_out_data),
    .blk_xfer_out_data_valid (blk_xfer_out_data_valid)
  );

  usb_xfer_checker i_checker (
    .clk                     (clk),
    .rst                     (rst),
    .trn_type                (trn_type),
    .trn_endpoint            (trn_endpoint),
    .trn_start               (trn_start),
    .blk_xfer_in_has_data    (blk_xfer_in_has_data),
    .blk_xfer_out_ready_read (blk_xfer_out_ready_read),
    .rx_trn_valid            (rx_trn_valid),
    .rx_trn_end              (rx_trn_end),
    .rx_trn_hsk_type         (rx_trn_hsk_type),
    .rx_trn_hsk_received     (rx_trn_hsk_received),
    .tx_trn_hsk_type         (tx_trn_hsk_type),
    .tx_trn_send_hsk         (tx_trn_send_hsk),
    .tx_trn_hsk_sended       (tx_trn_hsk_sended),
    .tx_trn_data_type        (tx_trn_data_type),
    .tx_trn_data_start       (tx_trn_data_start),
    .tx_trn_data             (tx_trn_data),
    .tx_trn_data_valid       (tx_trn_data_valid),
    .tx_trn_data_ready       (tx_trn_data_ready),
    .tx_trn_data_last        (tx_trn_data_last),
    .blk_xfer_endpoint       (blk_xfer_endpoint),
    .blk_in_xfer             (blk_in_xfer),
    .blk_out_xfer            (blk_out_xfer),
    .blk_xfer_in_data_valid  (blk_xfer_in_data_valid),
    .blk_xfer_in_data_ready  (blk_xfer_in_data_ready),
    .blk_xfer_out_data       (blk_xfer_out_data),
    .blk_xfer_out_data_valid (blk_xfer_out_data_valid),
    .row_idx                 (row_idx),
    .row_bytes               (row_bytes),
    .row_last                (row_last),
    .errors                  (errors),
    .checks                  (checks)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic load_table();
    // Endpoint 1 walks DATA0, DATA1, DATA0, then repeats DATA0 after a host NAK
    rows[0]  = '{TOKEN_IN,  4'd1, 1'b1, 8,   1'b1, HSK_ACK};
    rows[1]  = '{TOKEN_IN,  4'd1, 1'b1, 5,   1'b0, HSK_ACK};
    rows[2]  = '{TOKEN_IN,  4'd1, 1'b1, 4,   1'b1, HSK_NAK};
    rows[3]  = '{TOKEN_IN,  4'd1, 1'b1, 3,   1'b1, HSK_ACK};
    rows[4]  = '{TOKEN_IN,  4'd2, 1'b1, 6,   1'b1, HSK_ACK};
    rows[5]  = '{TOKEN_IN,  4'd1, 1'b1, 2,   1'b1, HSK_ACK};
    rows[6]  = '{TOKEN_IN,  4'd3, 1'b0, 0,   1'b0, HSK_ACK};
    rows[7]  = '{TOKEN_OUT, 4'd2, 1'b1, 7,   1'b0, HSK_ACK};
    rows[8]  = '{TOKEN_OUT, 4'd4, 1'b0, 3,   1'b0, HSK_ACK};
    // A long source without last is cut at the maximum packet size
    rows[9]  = '{TOKEN_IN,  4'd5, 1'b1, 600, 1'b0, HSK_ACK};
    rows[10] = '{TOKEN_IN,  4'd5, 1'b1, 10,  1'b1, HSK_ACK};
  endtask

  function automatic byte_t source_byte(input int row, input int idx);
    int v;
    v = row * 29 + idx * 7 + (idx >> 8) * 3;
    return v[7:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  task automatic set_source(input int r, input int idx);
    if (idx < rows[r].bytes) begin
      blk_xfer_in_data_valid = 1'b1;
      blk_xfer_in_data       = source_byte(r, idx);
      blk_xfer_in_data_last  = rows[r].last && (idx == rows[r].bytes - 1);
    end else begin
      blk_xfer_in_data_valid = 1'b0;
      blk_xfer_in_data       = 8'h00;
      blk_xfer_in_data_last  = 1'b0;
    end
  endtask

  task automatic issue_token(input int r);
    trn_type                = rows[r].tok;
    trn_endpoint            = rows[r].ep;
    blk_xfer_in_has_data    = rows[r].flag;
    blk_xfer_out_ready_read = rows[r].flag;
    trn_start               = 1'b1;
    @(negedge clk);
    trn_start               = 1'b0;
    blk_xfer_in_has_data    = 1'b0;
    blk_xfer_out_ready_read = 1'b0;
  endtask

  task automatic answer_hsk();
    while (!tx_trn_send_hsk) @(negedge clk);
    tx_trn_hsk_sended = 1'b1;
    @(negedge clk);
    tx_trn_hsk_sended = 1'b0;
  endtask

  task automatic run_in(input int r);
    int idx;
    logic step;
    idx = 0;
    // The source is valid before the sequencer enters the data phase
    set_source(r, idx);
    issue_token(r);
    while (!blk_in_xfer) @(negedge clk);
    while (blk_in_xfer) begin
      tx_trn_data_ready = ($urandom % 4) != 0;
      set_source(r, idx);
      step = blk_xfer_in_data_valid && tx_trn_data_ready;
      @(negedge clk);
      if (step) begin
        idx++;
      end
    end
    tx_trn_data_ready = 1'b0;
    set_source(r, rows[r].bytes);
    rx_trn_hsk_type     = rows[r].host;
    rx_trn_hsk_received = 1'b1;
    @(negedge clk);
    rx_trn_hsk_received = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_out(input int r);
    issue_token(r);
    while (!blk_out_xfer) @(negedge clk);
    for (int i = 0; i < rows[r].bytes; i++) begin
      rx_trn_valid = 1'b1;
      rx_trn_data  = source_byte(r, i);
      @(negedge clk);
    end
    rx_trn_valid = 1'b0;
    rx_trn_end   = 1'b1;
    @(negedge clk);
    rx_trn_end = 1'b0;
    answer_hsk();
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(62192));
    rst = 1'b1;
    trn_type = TOKEN_SETUP;
    trn_endpoint = '0;
    trn_start = 1'b0;
    rx_trn_data = '0;
    rx_trn_valid = 1'b0;
    rx_trn_end = 1'b0;
    rx_trn_hsk_type = HSK_ACK;
    rx_trn_hsk_received = 1'b0;
    tx_trn_hsk_sended = 1'b0;
    tx_trn_data_ready = 1'b0;
    blk_xfer_in_has_data = 1'b0;
    blk_xfer_in_data = '0;
    blk_xfer_in_data_valid = 1'b0;
    blk_xfer_in_data_last = 1'b0;
    blk_xfer_out_ready_read = 1'b0;
    row_idx = 0;
    row_bytes = 0;
    row_last = 1'b0;
    load_table();
    limit = 10;
    for (int i = 0; i < NUM_ROWS; i++) begin
      limit = limit + 4 * rows[i].bytes + 40;
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_idx   = r;
      row_bytes = rows[r].bytes;
      row_last  = rows[r].last;
      if (rows[r].tok == TOKEN_OUT) begin
        run_out(r);
      end else if (rows[r].flag) begin
        run_in(r);
      end else begin
        issue_token(r);
        answer_hsk();
        @(negedge clk);
      end
    end
    repeat (4) @(negedge clk);
    $display("Errors: %0d, checks done: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, a transaction never finished", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* testbench/usb_xfer_chk.sv */
`timescale 1ns/1ps

module usb_xfer_chk (
  input logic clk,
  input logic rst,
  input logic tx_trn_send_hsk,
  input logic tx_trn_hsk_sended,
  input logic tx_trn_data_start,
  input logic tx_trn_data_valid
);

  // A handshake and a data packet never go out at the same time
  hsk_data_excl: assert property (@(posedge clk) disable iff (rst)
    !(tx_trn_send_hsk && tx_trn_data_start))
    else $error("send_hsk and data_start are high together");

  data_valid_in_packet: assert property (@(posedge clk) disable iff (rst)
    tx_trn_data_valid |-> tx_trn_data_start)
    else $error("data_valid outside of a data packet");

  // The packet layer must see the handshake until it reports it sent
  hsk_held: assert property (@(posedge clk) disable iff (rst)
    (tx_trn_send_hsk && !tx_trn_hsk_sended) |=> tx_trn_send_hsk)
    else $error("send_hsk dropped before hsk_sended");

endmodule

bind usb_xfer_top usb_xfer_chk i_chk (
  .clk               (clk),
  .rst               (rst),
  .tx_trn_send_hsk   (tx_trn_send_hsk),
  .tx_trn_hsk_sended (tx_trn_hsk_sended),
  .tx_trn_data_start (tx_trn_data_start),
  .tx_trn_data_valid (tx_trn_data_valid)
);

/* testbench/usb_xfer_checker.sv */
`timescale 1ns/1ps

module usb_xfer_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  usb_xfer_pkg::token_t    trn_type,
  input  usb_xfer_pkg::endpoint_t trn_endpoint,
  input  logic                    trn_start,
  input  logic                    blk_xfer_in_has_data,
  input  logic                    blk_xfer_out_ready_read,
  input  logic                    rx_trn_valid,
  input  logic                    rx_trn_end,
  input  usb_xfer_pkg::hsk_t      rx_trn_hsk_type,
  input  logic                    rx_trn_hsk_received,
  input  usb_xfer_pkg::hsk_t      tx_trn_hsk_type,
  input  logic                    tx_trn_send_hsk,
  input  logic                    tx_trn_hsk_sended,
  input  logic [1:0]              tx_trn_data_type,
  input  logic                    tx_trn_data_start,
  input  usb_xfer_pkg::byte_t     tx_trn_data,
  input  logic                    tx_trn_data_valid,
  input  logic                    tx_trn_data_ready,
  input  logic                    tx_trn_data_last,
  input  usb_xfer_pkg::endpoint_t blk_xfer_endpoint,
  input  logic                    blk_in_xfer,
  input  logic                    blk_out_xfer,
  input  logic                    blk_xfer_in_data_valid,
  input  logic                    blk_xfer_in_data_ready,
  input  usb_xfer_pkg::byte_t     blk_xfer_out_data,
  input  logic                    blk_xfer_out_data_valid,
  input  int                      row_idx,
  input  int                      row_bytes,
  input  logic                    row_last,
  output int                      errors,
  output int                      checks
);
  import usb_xfer_pkg::*;

  // Model of the per-endpoint DATA0/DATA1 toggles
  logic [NUM_ENDPOINTS-1:0] tog;
  logic tok_in;
  logic tok_has;
  logic tok_ack;
  endpoint_t tok_ep;
  logic in_pending;
  logic start_q;
  // Expected IN and OUT data phases, and the tokens about to start one
  logic in_exp;
  logic out_exp;
  logic pend_in;
  logic pend_out;
  int cnt;
  int out_cnt;
  int exp_len;
  byte_t exp_data;
  logic exp_last;
  hsk_t exp_hsk;

  function automatic byte_t expected_byte(input int row, input int idx);
    int v;
    v = row * 29 + idx * 7 + (idx >> 8) * 3;
    return v[7:0];
  endfunction

  task automatic compare(input logic ok, input string msg);
    checks++;
    if (!ok) begin
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      tog = '0;
      in_pending = 1'b0;
      start_q = 1'b0;
      in_exp = 1'b0;
      out_exp = 1'b0;
      pend_in = 1'b0;
      pend_out = 1'b0;
      tok_in = 1'b0;
      tok_has = 1'b0;
      tok_ack = 1'b0;
      tok_ep = '0;
      cnt = 0;
      out_cnt = 0;
      errors = 0;
      checks = 0;
    end else begin
      // Transfer levels follow the modeled data phases
      compare(tx_trn_data_start === in_exp,
              $sformatf("data_start is %b, expected %b", tx_trn_data_start, in_exp));
      compare(blk_in_xfer === in_exp,
              $sformatf("blk_in_xfer is %b, expected %b", blk_in_xfer, in_exp));
      compare(blk_out_xfer === out_exp,
              $sformatf("blk_out_xfer is %b, expected %b", blk_out_xfer, out_exp));
      compare(blk_xfer_in_data_ready === (in_exp && tx_trn_data_ready),
              "blk_xfer_in_data_ready does not follow tx_trn_data_ready");

      if (trn_start && ((trn_type == TOKEN_IN) || (trn_type == TOKEN_OUT))) begin
        tok_in  = (trn_type == TOKEN_IN);
        tok_ep  = trn_endpoint;
        tok_has = blk_xfer_in_has_data;
        tok_ack = blk_xfer_out_ready_read;
        cnt     = 0;
        out_cnt = 0;
      end

      ////////////////////////////////////////////////////////////
      // Bulk IN data phase
      ////////////////////////////////////////////////////////////
      if (tx_trn_data_start) begin
        compare(tok_in && tok_has, "data_start without an IN token that has data");
        compare(tx_trn_data_type === {tog[tok_ep], 1'b0},
                $sformatf("data type %b on endpoint %0d", tx_trn_data_type, tok_ep));
        compare(blk_xfer_endpoint === tok_ep, "wrong endpoint during IN");
        in_pending = 1'b1;
      end
      if (tx_trn_data_valid && tx_trn_data_ready) begin
        exp_data = expected_byte(row_idx, cnt);
        exp_last = (cnt == BULK_MAX_PACKET - 1) || (row_last && (cnt == row_bytes - 1));
        compare(tx_trn_data === exp_data,
                $sformatf("IN byte %0d is %h, expected %h", cnt, tx_trn_data, exp_data));
        compare(tx_trn_data_last === exp_last,
                $sformatf("IN byte %0d has data_last %b", cnt, tx_trn_data_last));
        cnt++;
        if (exp_last) begin
          in_exp = 1'b0;
        end
      end
      // A source running dry ends the packet
      if (in_exp && !blk_xfer_in_data_valid) begin
        in_exp = 1'b0;
      end
      if (start_q && !tx_trn_data_start) begin
        exp_len = (row_bytes > BULK_MAX_PACKET) ? BULK_MAX_PACKET : row_bytes;
        compare(cnt == exp_len, $sformatf("IN packet has %0d bytes, expected %0d", cnt, exp_len));
      end
      start_q = tx_trn_data_start;

      // Only a host ACK advances the toggle
      if (rx_trn_hsk_received && in_pending) begin
        if (rx_trn_hsk_type == HSK_ACK) begin
          tog[tok_ep] = ~tog[tok_ep];
        end
        in_pending = 1'b0;
      end

      ////////////////////////////////////////////////////////////
      // Bulk OUT data and handshakes
      ////////////////////////////////////////////////////////////
      if (rx_trn_valid) begin
        exp_data = expected_byte(row_idx, out_cnt);
        compare(blk_xfer_out_data_valid === 1'b1, "OUT byte not forwarded");
        compare(blk_xfer_out_data === exp_data,
                $sformatf("OUT byte %0d is %h, expected %h", out_cnt, blk_xfer_out_data, exp_data));
        out_cnt++;
      end
      if (out_exp && rx_trn_end) begin
        out_exp = 1'b0;
      end
      if (tx_trn_send_hsk && tx_trn_hsk_sended) begin
        exp_hsk = (!tok_in && tok_ack) ? HSK_ACK : HSK_NAK;
        compare(!(tok_in && tok_has), "handshake sent for an IN that has data");
        compare(tx_trn_hsk_type === exp_hsk,
                $sformatf("handshake %b, expected %b", tx_trn_hsk_type, exp_hsk));
        if (!tok_in) begin
          compare(out_cnt == row_bytes, $sformatf("OUT forwarded %0d bytes", out_cnt));
        end
      end

      // A data phase opens one edge after the decoder registers its token
      if (pend_in) begin
        in_exp = 1'b1;
      end
      if (pend_out) begin
        out_exp = 1'b1;
      end
      pend_in  = trn_start && (trn_type == TOKEN_IN) && blk_xfer_in_has_data;
      pend_out = trn_start && (trn_type == TOKEN_OUT);
    end
  end

endmodule

/* source/usb_xfer_top.sv */
`timescale 1ns/1ps

module usb_xfer_top (
  input  logic                    clk,
  input  logic                    rst,
  // Token from the packet layer
  input  usb_xfer_pkg::token_t    trn_type,
  input  usb_xfer_pkg::endpoint_t trn_endpoint,
  input  logic                    trn_start,
  // Received data and handshakes
  input  usb_xfer_pkg::byte_t     rx_trn_data,
  input  logic                    rx_trn_valid,
  input  logic                    rx_trn_end,
  input  usb_xfer_pkg::hsk_t      rx_trn_hsk_type,
  input  logic                    rx_trn_hsk_received,
  // Transmit side of the packet layer
  output usb_xfer_pkg::hsk_t      tx_trn_hsk_type,
  output logic                    tx_trn_send_hsk,
  input  logic                    tx_trn_hsk_sended,
  output logic [1:0]              tx_trn_data_type,
  output logic                    tx_trn_data_start,
  output usb_xfer_pkg::byte_t     tx_trn_data,
  output logic                    tx_trn_data_valid,
  input  logic                    tx_trn_data_ready,
  output logic                    tx_trn_data_last,
  // Bulk endpoints
  output usb_xfer_pkg::endpoint_t blk_xfer_endpoint,
  output logic                    blk_in_xfer,
  output logic                    blk_out_xfer,
  input  logic                    blk_xfer_in_has_data,
  input  usb_xfer_pkg::byte_t     blk_xfer_in_data,
  input  logic                    blk_xfer_in_data_valid,
  output logic                    blk_xfer_in_data_ready,
  input  logic                    blk_xfer_in_data_last,
  input  logic                    blk_xfer_out_ready_read,
  output usb_xfer_pkg::byte_t     blk_xfer_out_data,
  output logic                    blk_xfer_out_data_valid
);

  logic idle;
  logic in_active;
  logic in_done;

  xfer_req_if req ();

  token_decoder i_token_decoder (
    .clk                     (clk),
    .rst                     (rst),
    .trn_type                (trn_type),
    .trn_endpoint            (trn_endpoint),
    .trn_start               (trn_start),
    .blk_xfer_in_has_data    (blk_xfer_in_has_data),
    .blk_xfer_out_ready_read (blk_xfer_out_ready_read),
    .idle                    (idle),
    .req                     (req.decoder)
  );

  xfer_sequencer i_xfer_sequencer (
    .clk                     (clk),
    .rst                     (rst),
    .req                     (req.sequencer),
    .idle                    (idle),
    .in_active               (in_active),
    .in_done                 (in_done),
    .rx_trn_data             (rx_trn_data),
    .rx_trn_valid            (rx_trn_valid),
    .rx_trn_end              (rx_trn_end),
    .rx_trn_hsk_type         (rx_trn_hsk_type),
    .rx_trn_hsk_received     (rx_trn_hsk_received),
    .tx_trn_hsk_sended       (tx_trn_hsk_sended),
    .tx_trn_hsk_type         (tx_trn_hsk_type),
    .tx_trn_send_hsk         (tx_trn_send_hsk),
    .tx_trn_data_type        (tx_trn_data_type),
    .tx_trn_data_start       (tx_trn_data_start),
    .blk_xfer_endpoint       (blk_xfer_endpoint),
    .blk_in_xfer             (blk_in_xfer),
    .blk_out_xfer            (blk_out_xfer),
    .blk_xfer_out_data       (blk_xfer_out_data),
    .blk_xfer_out_data_valid (blk_xfer_out_data_valid)
  );

  in_data_mover i_in_data_mover (
    .clk                    (clk),
    .rst                    (rst),
    .in_active              (in_active),
    .in_done                (in_done),
    .blk_xfer_in_data       (blk_xfer_in_data),
    .blk_xfer_in_data_valid (blk_xfer_in_data_valid),
    .blk_xfer_in_data_last  (blk_xfer_in_data_last),
    .blk_xfer_in_data_ready (blk_xfer_in_data_ready),
    .tx_trn_data_ready      (tx_trn_data_ready),
    .tx_trn_data            (tx_trn_data),
    .tx_trn_data_valid      (tx_trn_data_valid),
    .tx_trn_data_last       (tx_trn_data_last)
  );

endmodule

/* source/in_data_mover.sv */
`timescale 1ns/1ps

module in_data_mover (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_active,
  output logic                in_done,
  input  usb_xfer_pkg::byte_t blk_xfer_in_data,
  input  logic                blk_xfer_in_data_valid,
  input  logic                blk_xfer_in_data_last,
  output logic                blk_xfer_in_data_ready,
  input  logic                tx_trn_data_ready,
  output usb_xfer_pkg::byte_t tx_trn_data,
  output logic                tx_trn_data_valid,
  output logic                tx_trn_data_last
);
  import usb_xfer_pkg::*;

  // Bytes already accepted by the packet layer in this packet
  pkt_count_t byte_count;
  logic accept;
  logic count_full;
  logic end_byte;

  ////////////////////////////////////////////////////////////
  // Byte path
  ////////////////////////////////////////////////////////////

  assign tx_trn_data            = blk_xfer_in_data;
  assign tx_trn_data_valid      = in_active && blk_xfer_in_data_valid;
  assign blk_xfer_in_data_ready = in_active && tx_trn_data_ready;

  // A byte moves only when both sides agree in the same cycle
  assign accept = tx_trn_data_valid && tx_trn_data_ready;

  ////////////////////////////////////////////////////////////
  // Packet end
  ////////////////////////////////////////////////////////////

  // The byte at this count would be the last that fits the packet
  assign count_full = (byte_count == pkt_count_t'(BULK_MAX_PACKET - 1));

  assign end_byte = blk_xfer_in_data_last || count_full;

  assign tx_trn_data_last = tx_trn_data_valid && end_byte;

  // A source running dry ends the packet short, without data_last
  assign in_done = in_active && ((accept && end_byte) || !blk_xfer_in_data_valid);

  always_ff @(posedge clk) begin
    if (rst || !in_active) begin
      byte_count <= '0;
    end else if (accept) begin
      byte_count <= byte_count + 1'b1;
    end
  end

endmodule

/* source/xfer_sequencer.sv */
`timescale 1ns/1ps

module xfer_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  xfer_req_if.sequencer           req,
  output logic                    idle,
  output logic                    in_active,
  input  logic                    in_done,
  input  usb_xfer_pkg::byte_t     rx_trn_data,
  input  logic                    rx_trn_valid,
  input  logic                    rx_trn_end,
  input  usb_xfer_pkg::hsk_t      rx_trn_hsk_type,
  input  logic                    rx_trn_hsk_received,
  input  logic                    tx_trn_hsk_sended,
  output usb_xfer_pkg::hsk_t      tx_trn_hsk_type,
  output logic                    tx_trn_send_hsk,
  output logic [1:0]              tx_trn_data_type,
  output logic                    tx_trn_data_start,
  output usb_xfer_pkg::endpoint_t blk_xfer_endpoint,
  output logic                    blk_in_xfer,
  output logic                    blk_out_xfer,
  output usb_xfer_pkg::byte_t     blk_xfer_out_data,
  output logic                    blk_xfer_out_data_valid
);
  import usb_xfer_pkg::*;

  seq_state_t state;
  endpoint_t cur_endpoint;
  hsk_t hsk_code;
  // One DATA0/DATA1 bit per endpoint, set means DATA1
  logic [NUM_ENDPOINTS-1:0] toggles;

  ////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_IDLE;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (req.valid) begin
            case (req.kind)
              XFER_BULK_IN:     state <= SEQ_BULK_IN;
              XFER_BULK_IN_NAK: state <= SEQ_BULK_IN_NAK;
              XFER_BULK_OUT:    state <= SEQ_BULK_OUT;
              default:          state <= SEQ_IDLE;
            endcase
          end
        end
        SEQ_BULK_IN: begin
          if (in_done) begin
            state <= SEQ_BULK_IN_ACK;
          end
        end
        SEQ_BULK_IN_ACK: begin
          // Any host handshake closes the IN, the toggle logic sorts ACK out
          if (rx_trn_hsk_received) begin
            state <= SEQ_IDLE;
          end
        end
        SEQ_BULK_IN_NAK: begin
          if (tx_trn_hsk_sended) begin
            state <= SEQ_IDLE;
          end
        end
        SEQ_BULK_OUT: begin
          if (rx_trn_end) begin
            state <= SEQ_BULK_OUT_HSK;
          end
        end
        SEQ_BULK_OUT_HSK: begin
          if (tx_trn_hsk_sended) begin
            state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Endpoint and our handshake answer are captured with the request
  always_ff @(posedge clk) begin
    if ((state == SEQ_IDLE) && req.valid) begin
      cur_endpoint <= req.endpoint;
      if (req.kind == XFER_BULK_OUT) begin
        hsk_code <= req.out_ack ? HSK_ACK : HSK_NAK;
      end else begin
        hsk_code <= HSK_NAK;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Data toggles
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      toggles <= '0;
    end else if ((state == SEQ_BULK_IN_ACK) && rx_trn_hsk_received &&
                 (rx_trn_hsk_type == HSK_ACK)) begin
      toggles[cur_endpoint] <= ~toggles[cur_endpoint];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign idle      = (state == SEQ_IDLE);
  assign in_active = (state == SEQ_BULK_IN);

  assign tx_trn_data_start = in_active;
  assign blk_in_xfer       = in_active;
  assign blk_out_xfer      = (state == SEQ_BULK_OUT);

  assign tx_trn_send_hsk = (state == SEQ_BULK_IN_NAK) || (state == SEQ_BULK_OUT_HSK);
  assign tx_trn_hsk_type = hsk_code;

  // DATA0 is PID code 00 and DATA1 is 10
  assign tx_trn_data_type  = {toggles[cur_endpoint], 1'b0};
  assign blk_xfer_endpoint = cur_endpoint;

  // OUT bytes reach the endpoint even when we will answer NAK
  assign blk_xfer_out_data       = rx_trn_data;
  assign blk_xfer_out_data_valid = blk_out_xfer && rx_trn_valid;

endmodule

/* source/token_decoder.sv */
`timescale 1ns/1ps

module token_decoder (
  input  logic                    clk,
  input  logic                    rst,
  input  usb_xfer_pkg::token_t    trn_type,
  input  usb_xfer_pkg::endpoint_t trn_endpoint,
  input  logic                    trn_start,
  input  logic                    blk_xfer_in_has_data,
  input  logic                    blk_xfer_out_ready_read,
  input  logic                    idle,
  xfer_req_if.decoder             req
);
  import usb_xfer_pkg::*;

  logic bulk_token;
  logic take;

  // Only IN and OUT tokens start a bulk transaction, SETUP is ignored
  assign bulk_token = (trn_type == TOKEN_IN) || (trn_type == TOKEN_OUT);

  // A request still on the interface has not been taken by the sequencer yet
  assign take = trn_start && bulk_token && idle && !req.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= take;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take) begin
      req.endpoint <= trn_endpoint;
      req.out_ack  <= 1'b0;
      if (trn_type == TOKEN_IN) begin
        // Without a complete packet the IN token gets a NAK
        if (blk_xfer_in_has_data) begin
          req.kind <= XFER_BULK_IN;
        end else begin
          req.kind <= XFER_BULK_IN_NAK;
        end
      end else begin
        req.kind <= XFER_BULK_OUT;
        // The endpoint must take a full packet now, or the host retries
        req.out_ack <= blk_xfer_out_ready_read;
      end
    end
  end

endmodule

/* source/xfer_req_if.sv */
`timescale 1ns/1ps

interface xfer_req_if;
  import usb_xfer_pkg::*;

  // One-cycle strobe, the other fields are valid with it
  logic valid;
  xfer_kind_t kind;
  endpoint_t endpoint;
  // OUT data will be acknowledged
  logic out_ack;

  modport decoder (
    output valid,
    output kind,
    output endpoint,
    output out_ack
  );

  modport sequencer (
    input valid,
    input kind,
    input endpoint,
    input out_ack
  );

endinterface

/* source/usb_xfer_pkg.sv */
package usb_xfer_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int NUM_ENDPOINTS = 16;

  // High-speed bulk packets carry at most 512 bytes
  localparam int BULK_MAX_PACKET = 512;
  localparam int PKT_COUNT_W = 10;

  typedef logic [7:0] byte_t;
  typedef logic [3:0] endpoint_t;
  typedef logic [PKT_COUNT_W-1:0] pkt_count_t;

  ////////////////////////////////////////////////////////////
  // Codes and states
  ////////////////////////////////////////////////////////////

  // Handshake PIDs as the packet layer encodes them
  typedef enum logic [1:0] {
    HSK_ACK   = 2'b00,
    HSK_NYET  = 2'b01,
    HSK_NAK   = 2'b10,
    HSK_STALL = 2'b11
  } hsk_t;

  typedef enum logic [1:0] {
    TOKEN_OUT   = 2'b00,
    TOKEN_IN    = 2'b10,
    TOKEN_SETUP = 2'b11
  } token_t;

  typedef enum logic [1:0] {
    XFER_BULK_IN,
    XFER_BULK_IN_NAK,
    XFER_BULK_OUT
  } xfer_kind_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_BULK_IN,
    SEQ_BULK_IN_ACK,
    SEQ_BULK_IN_NAK,
    SEQ_BULK_OUT,
    SEQ_BULK_OUT_HSK
  } seq_state_t;

endpackage
